// File: Bender.yml
package:
  name: udp_loopback

sources:
  - target: any(rtl, test)
    files:
      - source/net_cfg_pkg.sv
      - source/mold_pkg.sv
      - source/udp_port_filter.sv
      - source/payload_fifo.sv
      - source/mold_udp64_decoder.sv
      - source/udp_loopback_top.sv
  - target: test
    files:
      - tests/udp_loopback_sva.sv
      - tests/udp_loopback_tb.sv

// File: source/mold_pkg.sv
`default_nettype none

package mold_pkg;

  // moldUDP64 header fields, all big-endian on the wire
  typedef logic [79:0] mold_session_t;
  typedef logic [63:0] mold_seq_num_t;
  typedef logic [15:0] mold_count_t;

  // Length prefix in front of every message block
  typedef logic [15:0] mold_msg_len_t;

  // Header layout in bytes, session first
  localparam int SESSION_BYTES = 10;
  localparam int SEQ_NUM_BYTES = 8;
  localparam int COUNT_BYTES   = 2;
  localparam int HEADER_BYTES  = SESSION_BYTES + SEQ_NUM_BYTES + COUNT_BYTES;

  // Each message block starts with this many length bytes
  localparam int MSG_LEN_BYTES = 2;

  // Board LEDs show the low bits of the sequence number
  localparam int LED_COUNT = 16;

endpackage

`default_nettype wire

// File: source/mold_udp64_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module mold_udp64_decoder (
  input  logic                            clk,
  input  logic                            rst,

  // Accepted payload bytes, one per strobe
  input  net_cfg_pkg::byte_t              byte_data,
  input  logic                            byte_valid,
  input  logic                            byte_last,

  output mold_pkg::mold_session_t         session,
  output mold_pkg::mold_seq_num_t         seq_num,
  output mold_pkg::mold_count_t           message_cnt,
  output mold_pkg::mold_msg_len_t         message_length,
  output net_cfg_pkg::byte_t              message_data,
  output logic                            message_valid,
  output logic [mold_pkg::LED_COUNT-1:0]  leds
);

  import net_cfg_pkg::*;
  import mold_pkg::*;

  // Byte index within the header, reused for the length prefix
  logic [$clog2(HEADER_BYTES)-1:0] byte_cnt;

  // Phase flags, both low while the header is being parsed
  logic hdr_done;
  logic data_phase;

  // Data bytes still to come in the current message
  mold_msg_len_t remaining;

  mold_seq_num_t seq_next;
  mold_msg_len_t len_next;

  // Big-endian fields shift in from the right
  assign seq_next = {seq_num[$bits(mold_seq_num_t)-9:0], byte_data};
  assign len_next = {message_length[$bits(mold_msg_len_t)-9:0], byte_data};

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      byte_cnt       <= '0;
      hdr_done       <= 1'b0;
      data_phase     <= 1'b0;
      remaining      <= '0;
      session        <= '0;
      seq_num        <= '0;
      message_cnt    <= '0;
      message_length <= '0;
      message_data   <= '0;
      message_valid  <= 1'b0;
      leds           <= '0;
    end
    else
    begin
      message_valid <= 1'b0;
      if (byte_valid)
      begin
        if (!hdr_done)
        begin
          if (byte_cnt < SESSION_BYTES)
          begin
            session <= {session[$bits(mold_session_t)-9:0], byte_data};
          end
          else if (byte_cnt < SESSION_BYTES + SEQ_NUM_BYTES)
          begin
            seq_num <= seq_next;
            // LEDs only move once the full sequence number is in
            if (byte_cnt == SESSION_BYTES + SEQ_NUM_BYTES - 1)
            begin
              leds <= seq_next[LED_COUNT-1:0];
            end
          end
          else if (byte_cnt < SESSION_BYTES + SEQ_NUM_BYTES + COUNT_BYTES)
          begin
            message_cnt <= {message_cnt[$bits(mold_count_t)-9:0], byte_data};
          end
          if (byte_cnt == HEADER_BYTES - 1)
          begin
            byte_cnt <= '0;
            hdr_done <= 1'b1;
          end
          else
          begin
            byte_cnt <= byte_cnt + 1'b1;
          end
        end
        else if (!data_phase)
        begin
          message_length <= len_next;
          if (byte_cnt == MSG_LEN_BYTES - 1)
          begin
            byte_cnt   <= '0;
            remaining  <= len_next;
            // Empty message goes straight to the next length prefix
            data_phase <= (len_next != '0);
          end
          else
          begin
            byte_cnt <= byte_cnt + 1'b1;
          end
        end
        else
        begin
          message_data  <= byte_data;
          message_valid <= 1'b1;
          remaining     <= remaining - 1'b1;
          if (remaining == 1)
          begin
            data_phase <= 1'b0;
          end
        end

        // End of datagram, next byte starts a new header
        if (byte_last)
        begin
          byte_cnt   <= '0;
          hdr_done   <= 1'b0;
          data_phase <= 1'b0;
        end
      end
    end
  end

endmodule

`default_nettype wire

// File: source/net_cfg_pkg.sv
`default_nettype none

package net_cfg_pkg;

  // IPv4 address as seen on the UDP header stream
  typedef logic [31:0] ip_addr_t;

  // UDP port number
  typedef logic [15:0] udp_port_t;

  // UDP length field, header included
  typedef logic [15:0] udp_len_t;

  // One payload byte per stream beat
  typedef logic [7:0] byte_t;

  // Frames sent to this port are echoed back to the sender
  localparam udp_port_t LOOPBACK_PORT = 16'd1234;

  // Default depth of the loopback payload buffer, in bytes
  localparam int PAYLOAD_FIFO_DEPTH = 8192;

endpackage

`default_nettype wire

// File: source/payload_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module payload_fifo #(
  parameter int DEPTH = net_cfg_pkg::PAYLOAD_FIFO_DEPTH
) (
  input  logic               clk,
  input  logic               rst,

  input  net_cfg_pkg::byte_t in_data,
  input  logic               in_valid,
  output logic               in_ready,
  input  logic               in_last,

  output net_cfg_pkg::byte_t out_data,
  output logic               out_valid,
  input  logic               out_ready,
  output logic               out_last
);

  import net_cfg_pkg::*;

  localparam int ADDR_W = $clog2(DEPTH);

  // Byte and last flag stored side by side, last in the top bit
  logic [$bits(byte_t):0] mem [DEPTH];

  // One extra bit to tell full from empty
  logic [ADDR_W:0] wr_ptr;
  logic [ADDR_W:0] rd_ptr;

  logic empty;
  logic full;
  logic wr_en;
  logic rd_en;

  assign empty = (wr_ptr == rd_ptr);
  assign full  = (wr_ptr[ADDR_W] != rd_ptr[ADDR_W]) &&
                 (wr_ptr[ADDR_W-1:0] == rd_ptr[ADDR_W-1:0]);

  assign in_ready = !full;
  assign wr_en    = in_valid && !full;

  // Refill the output register when it is free or being taken
  assign rd_en = !empty && (!out_valid || out_ready);

  always_ff @(posedge clk)
  begin
    if (wr_en)
    begin
      mem[wr_ptr[ADDR_W-1:0]] <= {in_last, in_data};
    end
    if (rd_en)
    begin
      {out_last, out_data} <= mem[rd_ptr[ADDR_W-1:0]];
    end
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      wr_ptr    <= '0;
      rd_ptr    <= '0;
      out_valid <= 1'b0;
    end
    else
    begin
      if (wr_en)
      begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (rd_en)
      begin
        rd_ptr    <= rd_ptr + 1'b1;
        out_valid <= 1'b1;
      end
      else if (out_ready)
      begin
        out_valid <= 1'b0;
      end
    end
  end

endmodule

`default_nettype wire

// File: source/udp_loopback_top.sv
`timescale 1ns/1ps
`default_nettype none

module udp_loopback_top (
  input  logic                            clk,
  input  logic                            rst,

  // Received UDP header
  input  logic                            rx_hdr_valid,
  output logic                            rx_hdr_ready,
  input  net_cfg_pkg::ip_addr_t           rx_source_ip,
  input  net_cfg_pkg::udp_port_t          rx_source_port,
  input  net_cfg_pkg::udp_port_t          rx_dest_port,
  input  net_cfg_pkg::udp_len_t           rx_length,

  // Received payload
  input  net_cfg_pkg::byte_t              rx_payload_data,
  input  logic                            rx_payload_valid,
  output logic                            rx_payload_ready,
  input  logic                            rx_payload_last,

  // Echo header
  output logic                            tx_hdr_valid,
  input  logic                            tx_hdr_ready,
  output net_cfg_pkg::ip_addr_t           tx_dest_ip,
  output net_cfg_pkg::udp_port_t          tx_source_port,
  output net_cfg_pkg::udp_port_t          tx_dest_port,
  output net_cfg_pkg::udp_len_t           tx_length,

  // Echo payload
  output net_cfg_pkg::byte_t              tx_payload_data,
  output logic                            tx_payload_valid,
  input  logic                            tx_payload_ready,
  output logic                            tx_payload_last,

  // Decoded market data
  output mold_pkg::mold_session_t         mold_session,
  output mold_pkg::mold_seq_num_t         mold_seq_num,
  output mold_pkg::mold_count_t           mold_message_cnt,
  output mold_pkg::mold_msg_len_t         mold_message_length,
  output net_cfg_pkg::byte_t              mold_message_data,
  output logic                            mold_message_valid,
  output logic [mold_pkg::LED_COUNT-1:0]  leds
);

  import net_cfg_pkg::*;

  byte_t fifo_in_data;
  logic  fifo_in_valid;
  logic  fifo_in_ready;
  logic  fifo_in_last;

  // Decoder sees exactly the bytes the FIFO takes
  logic  fifo_in_xfer;

  assign fifo_in_xfer = fifo_in_valid && fifo_in_ready;

  udp_port_filter udp_port_filter_inst (
    .clk              (clk),
    .rst              (rst),
    .rx_hdr_valid     (rx_hdr_valid),
    .rx_hdr_ready     (rx_hdr_ready),
    .rx_source_ip     (rx_source_ip),
    .rx_source_port   (rx_source_port),
    .rx_dest_port     (rx_dest_port),
    .rx_length        (rx_length),
    .tx_hdr_valid     (tx_hdr_valid),
    .tx_hdr_ready     (tx_hdr_ready),
    .tx_dest_ip       (tx_dest_ip),
    .tx_source_port   (tx_source_port),
    .tx_dest_port     (tx_dest_port),
    .tx_length        (tx_length),
    .rx_payload_data  (rx_payload_data),
    .rx_payload_valid (rx_payload_valid),
    .rx_payload_ready (rx_payload_ready),
    .rx_payload_last  (rx_payload_last),
    .fifo_in_data     (fifo_in_data),
    .fifo_in_valid    (fifo_in_valid),
    .fifo_in_last     (fifo_in_last),
    .fifo_in_ready    (fifo_in_ready)
  );

  payload_fifo #(
    .DEPTH (PAYLOAD_FIFO_DEPTH)
  ) payload_fifo_inst (
    .clk       (clk),
    .rst       (rst),
    .in_data   (fifo_in_data),
    .in_valid  (fifo_in_valid),
    .in_ready  (fifo_in_ready),
    .in_last   (fifo_in_last),
    .out_data  (tx_payload_data),
    .out_valid (tx_payload_valid),
    .out_ready (tx_payload_ready),
    .out_last  (tx_payload_last)
  );

  mold_udp64_decoder mold_udp64_decoder_inst (
    .clk            (clk),
    .rst            (rst),
    .byte_data      (fifo_in_data),
    .byte_valid     (fifo_in_xfer),
    .byte_last      (fifo_in_last),
    .session        (mold_session),
    .seq_num        (mold_seq_num),
    .message_cnt    (mold_message_cnt),
    .message_length (mold_message_length),
    .message_data   (mold_message_data),
    .message_valid  (mold_message_valid),
    .leds           (leds)
  );

endmodule

`default_nettype wire

// File: source/udp_port_filter.sv
`timescale 1ns/1ps
`default_nettype none

module udp_port_filter (
  input  logic                  clk,
  input  logic                  rst,

  // Received UDP header
  input  logic                  rx_hdr_valid,
  output logic                  rx_hdr_ready,
  input  net_cfg_pkg::ip_addr_t rx_source_ip,
  input  net_cfg_pkg::udp_port_t rx_source_port,
  input  net_cfg_pkg::udp_port_t rx_dest_port,
  input  net_cfg_pkg::udp_len_t rx_length,

  // Echo header towards the transmit stack
  output logic                  tx_hdr_valid,
  input  logic                  tx_hdr_ready,
  output net_cfg_pkg::ip_addr_t tx_dest_ip,
  output net_cfg_pkg::udp_port_t tx_source_port,
  output net_cfg_pkg::udp_port_t tx_dest_port,
  output net_cfg_pkg::udp_len_t tx_length,

  // Received payload
  input  net_cfg_pkg::byte_t    rx_payload_data,
  input  logic                  rx_payload_valid,
  output logic                  rx_payload_ready,
  input  logic                  rx_payload_last,

  // Payload of matching frames, towards the FIFO
  output net_cfg_pkg::byte_t    fifo_in_data,
  output logic                  fifo_in_valid,
  output logic                  fifo_in_last,
  input  logic                  fifo_in_ready
);

  import net_cfg_pkg::*;

  logic match;
  logic frame_open;
  logic hdr_xfer;
  logic last_xfer;

  // Frame state, one of these is set from header to last payload beat
  logic fwd_q;
  logic drop_q;

  assign match      = (rx_dest_port == LOOPBACK_PORT);
  assign frame_open = fwd_q | drop_q;

  // Next header waits until the open frame has seen its last beat
  assign tx_hdr_valid = rx_hdr_valid && match && !frame_open;
  assign rx_hdr_ready = !frame_open && (match ? tx_hdr_ready : 1'b1);

  // Reply goes back to the sender with the ports swapped
  assign tx_dest_ip     = rx_source_ip;
  assign tx_source_port = rx_dest_port;
  assign tx_dest_port   = rx_source_port;
  assign tx_length      = rx_length;

  assign hdr_xfer = rx_hdr_valid && rx_hdr_ready;

  // Payload steering follows the latched decision, not the live header
  assign fifo_in_data     = rx_payload_data;
  assign fifo_in_last     = rx_payload_last;
  assign fifo_in_valid    = rx_payload_valid && fwd_q;
  assign rx_payload_ready = (fwd_q && fifo_in_ready) || drop_q;

  assign last_xfer = rx_payload_valid && rx_payload_ready && rx_payload_last;

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      fwd_q  <= 1'b0;
      drop_q <= 1'b0;
    end
    else if (hdr_xfer)
    begin
      fwd_q  <= match;
      drop_q <= !match;
    end
    else if (last_xfer)
    begin
      fwd_q  <= 1'b0;
      drop_q <= 1'b0;
    end
  end

endmodule

`default_nettype wire

// File: tests/udp_loopback_sva.sv
`timescale 1ns/1ps
`default_nettype none

module udp_loopback_sva (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   rx_hdr_valid,
  input  logic                   rx_hdr_ready,
  input  net_cfg_pkg::udp_port_t rx_dest_port,
  input  logic                   rx_payload_xfer,
  input  logic                   rx_payload_last,
  input  logic                   tx_hdr_valid,
  input  logic                   tx_hdr_ready,
  input  logic [79:0]            tx_hdr_fields,
  input  logic                   tx_payload_valid,
  input  logic                   tx_payload_ready,
  input  logic [8:0]             tx_payload_beat,
  input  logic                   byte_xfer,
  input  logic                   byte_last,
  input  logic                   mold_message_valid
);

  import net_cfg_pkg::*;
  import mold_pkg::*;

  // Bumped by every failing assertion, read by the testbench
  int fail_count = 0;

  // Frame open from header transfer to the last payload transfer
  logic frame_open;

  // Bytes seen so far in the current datagram, saturating after the header
  int hdr_bytes;

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      frame_open <= 1'b0;
      hdr_bytes  <= 0;
    end
    else
    begin
      if (rx_hdr_valid && rx_hdr_ready)
      begin
        frame_open <= 1'b1;
      end
      else if (rx_payload_xfer && rx_payload_last)
      begin
        frame_open <= 1'b0;
      end
      if (byte_xfer)
      begin
        if (byte_last)
        begin
          hdr_bytes <= 0;
        end
        else if (hdr_bytes < HEADER_BYTES)
        begin
          hdr_bytes <= hdr_bytes + 1;
        end
      end
    end
  end

  // A waiting header keeps valid and its fields
  assert property (@(posedge clk) disable iff (rst)
    tx_hdr_valid && !tx_hdr_ready |=> tx_hdr_valid && $stable(tx_hdr_fields))
  else
  begin
    $error("tx_hdr valid or fields changed before ready");
    fail_count++;
  end

  // Same rule for the echoed payload
  assert property (@(posedge clk) disable iff (rst)
    tx_payload_valid && !tx_payload_ready |=> tx_payload_valid && $stable(tx_payload_beat))
  else
  begin
    $error("tx_payload valid or data changed before ready");
    fail_count++;
  end

  // Only a matching header goes out, and never while a frame is open
  assert property (@(posedge clk) disable iff (rst)
    tx_hdr_valid |-> rx_hdr_valid && (rx_dest_port == LOOPBACK_PORT) && !frame_open)
  else
  begin
    $error("tx_hdr_valid without a matching rx header or inside an open frame");
    fail_count++;
  end

  // Header bytes never produce a message byte
  assert property (@(posedge clk) disable iff (rst)
    byte_xfer && (hdr_bytes < HEADER_BYTES) |=> !mold_message_valid)
  else
  begin
    $error("mold_message_valid after a header byte");
    fail_count++;
  end

endmodule

bind udp_loopback_top udp_loopback_sva udp_loopback_sva_inst (
  .clk                (clk),
  .rst                (rst),
  .rx_hdr_valid       (rx_hdr_valid),
  .rx_hdr_ready       (rx_hdr_ready),
  .rx_dest_port       (rx_dest_port),
  .rx_payload_xfer    (rx_payload_valid && rx_payload_ready),
  .rx_payload_last    (rx_payload_last),
  .tx_hdr_valid       (tx_hdr_valid),
  .tx_hdr_ready       (tx_hdr_ready),
  .tx_hdr_fields      ({tx_dest_ip, tx_source_port, tx_dest_port, tx_length}),
  .tx_payload_valid   (tx_payload_valid),
  .tx_payload_ready   (tx_payload_ready),
  .tx_payload_beat    ({tx_payload_last, tx_payload_data}),
  .byte_xfer          (fifo_in_xfer),
  .byte_last          (fifo_in_last),
  .mold_message_valid (mold_message_valid)
);

`default_nettype wire

// File: tests/udp_loopback_tb.sv
`timescale 1ns/1ps
`default_nettype none

module udp_loopback_tb;

  import net_cfg_pkg::*;
  import mold_pkg::*;

  localparam int FRAMES   = 6;
  localparam int MAX_MSGS = 3;
  localparam int TIMEOUT  = 2000;
  localparam mold_session_t SESSION = "MKTFEED001";

  logic clk = 1'b0;
  logic rst;
  logic rx_hdr_valid, rx_hdr_ready, tx_hdr_valid, tx_hdr_ready;
  ip_addr_t rx_source_ip, tx_dest_ip;
  udp_port_t rx_source_port, rx_dest_port, tx_source_port, tx_dest_port;
  udp_len_t rx_length, tx_length;
  byte_t rx_payload_data, tx_payload_data, mold_message_data;
  logic rx_payload_valid, rx_payload_ready, rx_payload_last;
  logic tx_payload_valid, tx_payload_ready, tx_payload_last;
  mold_session_t mold_session;
  mold_seq_num_t mold_seq_num;
  mold_count_t mold_message_cnt;
  mold_msg_len_t mold_message_length;
  logic mold_message_valid;
  logic [LED_COUNT-1:0] leds, leds_before;

  // Frame table, one column per field
  udp_port_t t_dport [FRAMES] = '{16'd1234, 16'd80, 16'd1234, 16'd4000, 16'd1234, 16'd1234};
  udp_port_t t_sport [FRAMES] = '{16'd5000, 16'd5001, 16'd40000, 16'd123, 16'd6000, 16'd1234};
  ip_addr_t t_ip [FRAMES] = '{32'hc0a8_0164, 32'h0a00_0005, 32'hc0a8_01fe,
                              32'hac10_0001, 32'h0a01_0203, 32'hc0a8_0001};
  mold_seq_num_t t_seq [FRAMES] = '{64'h1a2b, 64'hffff, 64'h0123_4567_89ab_cdef,
                                    64'h1, 64'h0000_0001_0000_0002, 64'h00ff_00ff_00ff_8001};
  int t_nmsg [FRAMES] = '{2, 1, 3, 2, 0, 3};
  int t_len [FRAMES][MAX_MSGS] = '{'{5, 3, 0}, '{4, 0, 0}, '{1, 0, 7},
                                   '{2, 2, 0}, '{0, 0, 0}, '{12, 1, 9}};
  logic t_echo [FRAMES] = '{1'b1, 1'b0, 1'b1, 1'b0, 1'b1, 1'b1};

  // Expected and observed streams, headers, {last, byte} and {length, byte}
  logic [79:0] want_hdr_q[$], got_hdr_q[$], want_byte_q[$], got_byte_q[$];
  logic [79:0] want_msg_q[$], got_msg_q[$];

  int errors, tests, failed, errs_before, seen_before, valid_cycles;
  logic bp_on;
  logic [31:0] rnd;

  udp_loopback_top udp_loopback_top_inst (.*);

  always #5 clk = ~clk;

  // Random stalls on both transmit streams
  always @(negedge clk)
  begin
    if (bp_on)
    begin
      rnd = $urandom;
      tx_hdr_ready     <= rnd[0];
      tx_payload_ready <= rnd[1];
    end
  end

  // Sampled mid low phase, when everything driven at the falling edge has settled
  always @(negedge clk)
  begin
    #1;
    if (tx_hdr_valid || tx_payload_valid)
      valid_cycles++;
    if (tx_hdr_valid && tx_hdr_ready)
      got_hdr_q.push_back({tx_dest_ip, tx_source_port, tx_dest_port, tx_length});
    if (tx_payload_valid && tx_payload_ready)
      got_byte_q.push_back({tx_payload_last, tx_payload_data});
    if (mold_message_valid)
      got_msg_q.push_back({mold_message_length, mold_message_data});
  end

  task automatic stop_on_timeout(input string what);
    $display("Timeout at %0t ns while waiting for %s", $time, what);
    $display("Testbench failed");
    $finish;
  endtask

  task automatic send_frame(input int i);
    byte_t payload[$];
    byte_t b;
    mold_count_t cnt;
    mold_msg_len_t len;
    int n;
    cnt = mold_count_t'(t_nmsg[i]);
    for (int k = SESSION_BYTES - 1; k >= 0; k--)
      payload.push_back(SESSION[8*k +: 8]);
    for (int k = SEQ_NUM_BYTES - 1; k >= 0; k--)
      payload.push_back(t_seq[i][8*k +: 8]);
    payload.push_back(cnt[15:8]);
    payload.push_back(cnt[7:0]);
    for (int m = 0; m < t_nmsg[i]; m++)
    begin
      len = mold_msg_len_t'(t_len[i][m]);
      payload.push_back(len[15:8]);
      payload.push_back(len[7:0]);
      for (int d = 0; d < len; d++)
      begin
        b = byte_t'($urandom);
        payload.push_back(b);
        if (t_echo[i])
          want_msg_q.push_back({len, b});
      end
    end
    // Echo goes back to the sender with ports swapped
    if (t_echo[i])
    begin
      want_hdr_q.push_back({t_ip[i], t_dport[i], t_sport[i], udp_len_t'(payload.size() + 8)});
      foreach (payload[k])
        want_byte_q.push_back({k == payload.size() - 1, payload[k]});
    end
    @(negedge clk);
    rx_hdr_valid   <= 1'b1;
    rx_source_ip   <= t_ip[i];
    rx_source_port <= t_sport[i];
    rx_dest_port   <= t_dport[i];
    rx_length      <= udp_len_t'(payload.size() + 8);
    n = 0;
    #1;
    while (!rx_hdr_ready)
    begin
      n++;
      if (n > TIMEOUT)
        stop_on_timeout("rx_hdr_ready");
      @(negedge clk);
      #1;
    end
    @(negedge clk);
    rx_hdr_valid <= 1'b0;
    foreach (payload[k])
    begin
      rx_payload_valid <= 1'b1;
      rx_payload_data  <= payload[k];
      rx_payload_last  <= (k == payload.size() - 1);
      n = 0;
      #1;
      while (!rx_payload_ready)
      begin
        n++;
        if (n > TIMEOUT)
          stop_on_timeout("rx_payload_ready");
        @(negedge clk);
        #1;
      end
      @(negedge clk);
    end
    rx_payload_valid <= 1'b0;
    rx_payload_last  <= 1'b0;
  endtask

  task automatic wait_for_echo();
    int n;
    n = 0;
    while (got_byte_q.size() < want_byte_q.size())
    begin
      n++;
      if (n > TIMEOUT)
        stop_on_timeout("the echoed payload");
      @(negedge clk);
      #2;
    end
  endtask

  task automatic compare_queue(input string what, input logic [79:0] want[$],
                               input logic [79:0] got[$]);
    if (got.size() != want.size())
    begin
      $display("FAIL %0t: %s count %0d, expected %0d", $time, what, got.size(), want.size());
      errors++;
    end
    else
    begin
      foreach (want[k])
      begin
        if (got[k] !== want[k])
        begin
          $display("FAIL %0t: %s item %0d is %h, expected %h", $time, what, k, got[k], want[k]);
          errors++;
        end
      end
    end
  endtask

  task automatic compare_streams();
    compare_queue("tx header", want_hdr_q, got_hdr_q);
    compare_queue("tx payload", want_byte_q, got_byte_q);
    compare_queue("message", want_msg_q, got_msg_q);
    want_hdr_q.delete();
    got_hdr_q.delete();
    want_byte_q.delete();
    got_byte_q.delete();
    want_msg_q.delete();
    got_msg_q.delete();
  endtask

  task automatic report_test(input string name);
    tests++;
    if (errors == errs_before)
      $display("Test %s: ok", name);
    else
    begin
      failed++;
      $display("Test %s: FAIL with %0d errors", name, errors - errs_before);
    end
  endtask

  task automatic check_value(input string what, input logic [79:0] got, input logic [79:0] want);
    if (got !== want)
    begin
      $display("FAIL %0t: %s is %h, expected %h", $time, what, got, want);
      errors++;
    end
  endtask

  initial
  begin
    void'($urandom(32'hd6ee_fe89));
    errors           = 0;
    tests            = 0;
    failed           = 0;
    valid_cycles     = 0;
    bp_on            = 1'b0;
    rst              = 1'b1;
    rx_hdr_valid     = 1'b0;
    rx_source_ip     = '0;
    rx_source_port   = '0;
    rx_dest_port     = '0;
    rx_length        = '0;
    rx_payload_data  = '0;
    rx_payload_valid = 1'b0;
    rx_payload_last  = 1'b0;
    tx_hdr_ready     = 1'b1;
    tx_payload_ready = 1'b1;
    repeat (8) @(negedge clk);
    rst <= 1'b0;
    @(negedge clk);
    #1;
    errs_before = errors;
    check_value("tx_hdr_valid", tx_hdr_valid, 0);
    check_value("tx_payload_valid", tx_payload_valid, 0);
    check_value("mold_message_valid", mold_message_valid, 0);
    check_value("leds", leds, 0);
    report_test("reset state");

    // One frame at a time with the transmit side always ready
    for (int i = 0; i < FRAMES; i++)
    begin
      errs_before = errors;
      leds_before = leds;
      seen_before = valid_cycles;
      send_frame(i);
      wait_for_echo();
      compare_streams();
      if (t_echo[i])
      begin
        check_value("mold_session", mold_session, SESSION);
        check_value("mold_seq_num", mold_seq_num, t_seq[i]);
        check_value("mold_message_cnt", mold_message_cnt, t_nmsg[i]);
        check_value("leds", leds, t_seq[i][LED_COUNT-1:0]);
      end
      else
      begin
        check_value("leds after drop", leds, leds_before);
        check_value("tx valid cycles during drop", valid_cycles, seen_before);
      end
      report_test($sformatf("frame %0d %s", i, t_echo[i] ? "echo" : "drop"));
    end

    // The whole table again under random stalls
    errs_before = errors;
    bp_on = 1'b1;
    for (int i = 0; i < FRAMES; i++)
      send_frame(i);
    wait_for_echo();
    compare_streams();
    report_test("back-pressure");

    // Stream assertions in the bound checker count towards the result
    if (udp_loopback_top_inst.udp_loopback_sva_inst.fail_count != 0)
    begin
      $display("Stream assertions failed %0d times",
               udp_loopback_top_inst.udp_loopback_sva_inst.fail_count);
      errors += udp_loopback_top_inst.udp_loopback_sva_inst.fail_count;
    end

    $display("Summary: %0d tests, %0d failed, %0d errors", tests, failed, errors);
    if (errors == 0)
      $display("Testbench passed");
    else
      $display("Testbench failed");
    $finish;
  end

endmodule

`default_nettype wire

// File: udp_loopback.f
source/net_cfg_pkg.sv
source/mold_pkg.sv
source/udp_port_filter.sv
source/payload_fifo.sv
source/mold_udp64_decoder.sv
source/udp_loopback_top.sv
tests/udp_loopback_sva.sv
tests/udp_loopback_tb.sv
